//--- tests/golden_vectors.txt
// cmd addr wdata sel expect, hex. cmd 1 write, 2 read, 3 read of gp_i, 4 gp_o, 5 hold pu request,
// 6 wait for reset release, 7 pull sd_do low, 8 power-off hold then rst_p pulse, 0 ends the list
5 00000000 00000000 0 00000020
6 00000000 00000000 0 00000100
2 00000000 00000000 0 00000007
2 00000001 00000000 0 00000040
2 00000002 00000000 0 00000006
2 00000003 00000000 0 00000010
2 00000004 00000000 0 00000000
2 00000005 00000000 0 00001000
1 00000010 0000005a 1 00000000
2 00000011 00000000 0 0000005a
4 00000000 00000000 0 0000005a
3 00000010 00000000 0 00000000
2 00000100 00000000 0 00000000
7 00000000 00000000 0 00000004
1 0000000f 00000002 1 00000000
6 00000000 00000000 0 00000100
4 00000000 00000000 0 00000000
1 0000000f 00000001 1 00000000
8 00000000 00000000 0 00000200
6 00000000 00000000 0 00000100
2 00000002 00000000 0 00000006
0 00000000 00000000 0 00000000

//--- sim.f
common/soc_pkg.sv
common/devmap_pkg.sv
src/pi1_decoder.sv
devtbl/dev_table.sv
devtbl/reset_seq.sv
src/gpio_port.sv
src/soc_ctrl_top.sv
tests/tb_checker.sv
tests/tb_top.sv

//--- Bender.yml
package:
  name: soc_ctrl

sources:
  - files:
      - common/soc_pkg.sv
      - common/devmap_pkg.sv
      - src/pi1_decoder.sv
      - devtbl/dev_table.sv
      - devtbl/reset_seq.sv
      - src/gpio_port.sv
      - src/soc_ctrl_top.sv
  - target: test
    files:
      - tests/tb_checker.sv
      - tests/tb_top.sv

//--- tests/tb_top.sv
// testbench top with clock, reset, golden vector driver and DUT instance
`timescale 1ns/1ns

module tb_top
	import soc_pkg::*;
();

	localparam int MAX_VEC     = 64;
	localparam int BUS_TIMEOUT = 16;
	localparam int RST_TIMEOUT = 1024;

	logic                 clk100mhz_i;
	logic                 rst_p;
	logic                 pll_locked_i;
	logic                 pu_rst_req_i;
	pi1_op_t              pi1_op_i;
	logic [ADDRBITSZ-1:0] pi1_addr_i;
	logic [ARCHBITSZ-1:0] pi1_data_i;
	logic [SELBITSZ-1:0]  pi1_sel_i;
	logic [GPIOCOUNT-1:0] gp_i;
	logic                 sd_di_i;
	logic                 sd_do_i;
	logic                 dram_init_error_i;
	logic [ARCHBITSZ-1:0] pi1_data_o;
	logic                 pi1_rdy_o;
	logic [GPIOCOUNT-1:0] gp_o;
	logic                 sys_rst_o;

	logic [31:0] golden [0:5*MAX_VEC-1];
	integer      seed;
	int          vec_idx;
	logic        vec_run;
	int          test_cnt;
	int          fail_cnt;

	soc_ctrl_top soc_ctrl_top_i (
		.clk100mhz_i       (clk100mhz_i),
		.rst_p             (rst_p),
		.pll_locked_i      (pll_locked_i),
		.pu_rst_req_i      (pu_rst_req_i),
		.pi1_op_i          (pi1_op_i),
		.pi1_addr_i        (pi1_addr_i),
		.pi1_data_i        (pi1_data_i),
		.pi1_sel_i         (pi1_sel_i),
		.gp_i              (gp_i),
		.sd_di_i           (sd_di_i),
		.sd_do_i           (sd_do_i),
		.dram_init_error_i (dram_init_error_i),
		.pi1_data_o        (pi1_data_o),
		.pi1_rdy_o         (pi1_rdy_o),
		.gp_o              (gp_o),
		.sys_rst_o         (sys_rst_o)
	);

	tb_checker checker_i (
		.clk100mhz_i  (clk100mhz_i),
		.rst_p        (rst_p),
		.pu_rst_req_i (pu_rst_req_i),
		.op_i         (pi1_op_i),
		.rdy_i        (pi1_rdy_o),
		.rdata_i      (pi1_data_o),
		.gp_in_i      (gp_i),
		.gp_out_i     (gp_o),
		.sys_rst_i    (sys_rst_o),
		.vec_idx_i    (vec_idx),
		.vec_run_i    (vec_run),
		.test_cnt_o   (test_cnt),
		.fail_cnt_o   (fail_cnt)
	);

	initial clk100mhz_i = 1'b0;
	always #5 clk100mhz_i = ~clk100mhz_i;

	task automatic abort_run(input string why);
		$display("run stopped: %s", why);
		$display("Verification failed");
		$finish;
	endtask

	// waits a fixed number of edges and ends 1 ns after the last one
	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk100mhz_i);
		#1;
	endtask

	// master holds the op until it sees rdy, then drops it
	task automatic bus_access(input pi1_op_t op, input logic [31:0] addr,
		input logic [31:0] wdata, input logic [SELBITSZ-1:0] sel);
		int waited;
		pi1_op_i   = op;
		pi1_addr_i = addr[ADDRBITSZ-1:0];
		pi1_data_i = wdata;
		pi1_sel_i  = sel;
		waited     = 0;
		@(posedge clk100mhz_i);
		while (!pi1_rdy_o) begin
			waited++;
			if (waited == BUS_TIMEOUT) begin
				abort_run("no bus ready within the timeout");
			end
			@(posedge clk100mhz_i);
		end
		#1;
		pi1_op_i = PI1_NOOP;
	endtask

	task automatic wait_reset_release();
		int waited;
		waited = 0;
		@(posedge clk100mhz_i);
		while (sys_rst_o) begin
			waited++;
			if (waited == RST_TIMEOUT) begin
				abort_run("system reset was not released within the timeout");
			end
			@(posedge clk100mhz_i);
		end
		#1;
	endtask

	task automatic run_vector(input int idx);
		logic [31:0] cmd;
		logic [31:0] exp_val;
		cmd     = golden[5*idx];
		exp_val = golden[5*idx+4];
		case (cmd)
			32'h1: bus_access(PI1_WRITE, golden[5*idx+1], golden[5*idx+2],
				golden[5*idx+3][SELBITSZ-1:0]);
			32'h2, 32'h3: bus_access(PI1_READ, golden[5*idx+1], golden[5*idx+2],
				golden[5*idx+3][SELBITSZ-1:0]);
			32'h4: wait_cycles(1);
			32'h5: begin
				wait_cycles(int'(exp_val));
				pu_rst_req_i = 1'b0;
			end
			32'h6: wait_reset_release();
			32'h7: begin
				sd_do_i = 1'b0;
				wait_cycles(int'(exp_val));
				sd_do_i = 1'b1;
			end
			32'h8: begin
				wait_cycles(int'(exp_val));
				rst_p = 1'b1;
				wait_cycles(2);
				rst_p = 1'b0;
			end
			default: abort_run("unknown command in the golden vectors");
		endcase
	endtask

	initial begin
		seed              = 59925;
		rst_p             = 1'b1;
		pll_locked_i      = 1'b1;
		pu_rst_req_i      = 1'b1;
		pi1_op_i          = PI1_NOOP;
		pi1_addr_i        = '0;
		pi1_data_i        = '0;
		pi1_sel_i         = '0;
		gp_i              = GPIOCOUNT'($random(seed));
		sd_di_i           = 1'b1;
		sd_do_i           = 1'b1;
		dram_init_error_i = 1'b0;
		vec_idx           = 0;
		vec_run           = 1'b0;
		$readmemh("tests/golden_vectors.txt", golden);
		wait_cycles(2);
		rst_p = 1'b0;
		// command 0 ends the list
		for (int i = 0; (i < MAX_VEC) && (golden[5*i] != 32'h0); i++) begin
			@(posedge clk100mhz_i);
			#1;
			vec_idx = i;
			vec_run = 1'b1;
			run_vector(i);
			vec_run = 1'b0;
		end
		// give the checker one edge to judge the last vector
		@(posedge clk100mhz_i);
		@(posedge clk100mhz_i);
		$display("%0d tests, %0d passed, %0d failed", test_cnt, test_cnt - fail_cnt, fail_cnt);
		if ((fail_cnt == 0) && (test_cnt > 0)) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

//--- tests/tb_checker.sv
// testbench checker for bus reads, gpio outputs and system reset hold times
`timescale 1ns/1ns

module tb_checker
	import soc_pkg::*;
(
	input  logic                 clk100mhz_i,
	input  logic                 rst_p,
	input  logic                 pu_rst_req_i,
	input  pi1_op_t              op_i,
	input  logic                 rdy_i,
	input  logic [ARCHBITSZ-1:0] rdata_i,
	input  logic [GPIOCOUNT-1:0] gp_in_i,
	input  logic [GPIOCOUNT-1:0] gp_out_i,
	input  logic                 sys_rst_i,
	input  int                   vec_idx_i,
	input  logic                 vec_run_i,
	output int                   test_cnt_o,
	output int                   fail_cnt_o
);

	localparam int MAX_VEC = 64;
	// device table and gpio words answer in 2 cycles, the rest in 1
	localparam int MAPPED_WORDS = 20;

	logic [31:0]          golden [0:5*MAX_VEC-1];
	logic                 run_q;
	logic                 done_seen;
	logic                 rst_low_seen;
	logic                 pulse_seen;
	int                   lat;
	int                   run_len;
	int                   last_len;
	logic [ARCHBITSZ-1:0] rd_data;
	logic [GPIOCOUNT-1:0] gpo_last;

	initial begin
		$readmemh("tests/golden_vectors.txt", golden);
		test_cnt_o = 0;
		fail_cnt_o = 0;
		run_q      = 1'b0;
		run_len    = 0;
		last_len   = 0;
	end

	task automatic check_vector(input int idx);
		logic [31:0] cmd;
		logic [31:0] addr;
		logic [31:0] exp_val;
		int          exp_lat;
		bit          ok;
		cmd     = golden[5*idx];
		addr    = golden[5*idx+1];
		exp_val = golden[5*idx+4];
		exp_lat = (addr < MAPPED_WORDS) ? 2 : 1;
		ok      = 1'b1;
		case (cmd)
			32'h1: begin
				if (!done_seen) begin
					$display("test %0d: write was never answered", idx);
					ok = 1'b0;
				end
			end
			32'h2, 32'h3: begin
				// command 3 expects the pins as they were driven
				if (cmd == 32'h3) begin
					exp_val = 32'(gp_in_i);
				end
				if (!done_seen || (lat != exp_lat)) begin
					$display("test %0d: read took %0d cycles instead of %0d", idx, lat, exp_lat);
					ok = 1'b0;
				end else if (rd_data !== exp_val) begin
					$display("FAILED test %0d pi1_data_o got %h expected %h", idx, rd_data, exp_val);
					ok = 1'b0;
				end
			end
			32'h4: begin
				if (gpo_last !== exp_val[GPIOCOUNT-1:0]) begin
					$display("FAILED test %0d gp_o got %h expected %h", idx, gpo_last,
						exp_val[GPIOCOUNT-1:0]);
					ok = 1'b0;
				end
			end
			32'h5, 32'h8: begin
				if (rst_low_seen) begin
					$display("test %0d: system reset dropped while it had to be held", idx);
					ok = 1'b0;
				end
			end
			32'h6: begin
				if (last_len != int'(exp_val)) begin
					$display("FAILED test %0d sys_rst_o hold got %h expected %h", idx, last_len,
						exp_val);
					ok = 1'b0;
				end
				last_len = 0;
			end
			32'h7: begin
				if (!pulse_seen) begin
					$display("test %0d: no activity pulse on gp_o bit 0", idx);
					ok = 1'b0;
				end
			end
			default: begin
				$display("test %0d: unknown command %h", idx, cmd);
				ok = 1'b0;
			end
		endcase
		test_cnt_o++;
		if (ok) begin
			$display("test %0d passed, command %0h", idx, cmd);
		end else begin
			fail_cnt_o++;
		end
	endtask

	// system reset hold in edges after rst_p and the processor request drop with the release edge
	always @(posedge clk100mhz_i) begin
		if (rst_p || pu_rst_req_i) begin
			run_len = 0;
		end else if (sys_rst_i) begin
			run_len++;
		end else if (run_len != 0) begin
			last_len = run_len + 1;
			run_len  = 0;
		end
	end

	always @(posedge clk100mhz_i) begin
		if (vec_run_i) begin
			if (!run_q) begin
				lat          = 0;
				done_seen    = 1'b0;
				rst_low_seen = 1'b0;
				pulse_seen   = 1'b0;
			end
			if (!done_seen && (op_i != PI1_NOOP)) begin
				lat++;
				if (rdy_i) begin
					done_seen = 1'b1;
					rd_data   = rdata_i;
				end
			end
			if (!sys_rst_i) begin
				rst_low_seen = 1'b1;
			end
			if (gp_out_i[0]) begin
				pulse_seen = 1'b1;
			end
			gpo_last = gp_out_i;
		end else if (run_q) begin
			check_vector(vec_idx_i);
		end
		run_q = vec_run_i;
	end

endmodule

//--- src/soc_ctrl_top.sv
// board control top with bus decoder, device table, reset sequencer and gpio
`timescale 1ns/1ns

module soc_ctrl_top
	import soc_pkg::*;
(
	input  logic                 clk100mhz_i,
	input  logic                 rst_p,
	input  logic                 pll_locked_i,
	input  logic                 pu_rst_req_i,
	input  pi1_op_t              pi1_op_i,
	input  logic [ADDRBITSZ-1:0] pi1_addr_i,
	input  logic [ARCHBITSZ-1:0] pi1_data_i,
	input  logic [SELBITSZ-1:0]  pi1_sel_i,
	input  logic [GPIOCOUNT-1:0] gp_i,
	input  logic                 sd_di_i,
	input  logic                 sd_do_i,
	input  logic                 dram_init_error_i,
	output logic [ARCHBITSZ-1:0] pi1_data_o,
	output logic                 pi1_rdy_o,
	output logic [GPIOCOUNT-1:0] gp_o,
	output logic                 sys_rst_o
);

	pi1_op_t              devtbl_op;
	pi1_op_t              gpio_op;
	logic [ARCHBITSZ-1:0] devtbl_data;
	logic [ARCHBITSZ-1:0] gpio_data;
	logic                 devtbl_rdy;
	logic                 gpio_rdy;
	logic                 soft_warm;
	logic                 soft_off;

	pi1_decoder pi1_decoder_i (
		.clk100mhz_i   (clk100mhz_i),
		.pi1_op_i      (pi1_op_i),
		.pi1_addr_i    (pi1_addr_i),
		.devtbl_data_i (devtbl_data),
		.devtbl_rdy_i  (devtbl_rdy),
		.gpio_data_i   (gpio_data),
		.gpio_rdy_i    (gpio_rdy),
		.devtbl_op_o   (devtbl_op),
		.gpio_op_o     (gpio_op),
		.pi1_data_o    (pi1_data_o),
		.pi1_rdy_o     (pi1_rdy_o)
	);

	// slaves are aligned, so low address bits are their word offset
	dev_table dev_table_i (
		.clk100mhz_i (clk100mhz_i),
		.sys_rst_i   (sys_rst_o),
		.op_i        (devtbl_op),
		.addr_i      (pi1_addr_i[3:0]),
		.data_i      (pi1_data_i),
		.sel_i       (pi1_sel_i),
		.data_o      (devtbl_data),
		.rdy_o       (devtbl_rdy),
		.soft_warm_o (soft_warm),
		.soft_off_o  (soft_off)
	);

	reset_seq reset_seq_i (
		.clk100mhz_i  (clk100mhz_i),
		.rst_p        (rst_p),
		.pll_locked_i (pll_locked_i),
		.pu_rst_req_i (pu_rst_req_i),
		.soft_warm_i  (soft_warm),
		.soft_off_i   (soft_off),
		.sys_rst_o    (sys_rst_o)
	);

	gpio_port gpio_port_i (
		.clk100mhz_i       (clk100mhz_i),
		.sys_rst_i         (sys_rst_o),
		.op_i              (gpio_op),
		.addr_i            (pi1_addr_i[0]),
		.data_i            (pi1_data_i),
		.sel_i             (pi1_sel_i),
		.gp_i              (gp_i),
		.sd_di_i           (sd_di_i),
		.sd_do_i           (sd_do_i),
		.dram_init_error_i (dram_init_error_i),
		.data_o            (gpio_data),
		.rdy_o             (gpio_rdy),
		.gp_o              (gp_o)
	);

endmodule

//--- src/gpio_port.sv
// gpio input synchronizer, output register and activity stretcher
`timescale 1ns/1ns

module gpio_port
	import soc_pkg::*;
(
	input  logic                 clk100mhz_i,
	input  logic                 sys_rst_i,
	input  pi1_op_t              op_i,
	input  logic                 addr_i,
	input  logic [ARCHBITSZ-1:0] data_i,
	input  logic [SELBITSZ-1:0]  sel_i,
	input  logic [GPIOCOUNT-1:0] gp_i,
	input  logic                 sd_di_i,
	input  logic                 sd_do_i,
	input  logic                 dram_init_error_i,
	output logic [ARCHBITSZ-1:0] data_o,
	output logic                 rdy_o,
	output logic [GPIOCOUNT-1:0] gp_o
);

	logic [GPIOCOUNT-1:0]           gp_meta;
	logic [GPIOCOUNT-1:0]           gp_sync;
	logic [GPIOCOUNT-1:0]           gpo_r;
	logic                           ack_r;
	logic [ARCHBITSZ-1:0]           data_r;
	logic                           take_op;
	logic                           activity;
	logic [ACTIVITY_CNTR_BITSZ-1:0] activity_cntr;

	assign take_op = (op_i != PI1_NOOP) && !ack_r;

	// two flops against metastability
	always_ff @(posedge clk100mhz_i) begin
		gp_meta <= gp_i;
		gp_sync <= gp_meta;
	end

	always_ff @(posedge clk100mhz_i) begin
		if (sys_rst_i) begin
			ack_r <= 1'b0;
			gpo_r <= '0;
		end else begin
			ack_r <= take_op;
			if (take_op && (op_i != PI1_READ) && !addr_i && sel_i[0]) begin
				gpo_r <= data_i[GPIOCOUNT-1:0];
			end
		end
	end

	// word 0 reads the pins, word 1 the output register
	always_ff @(posedge clk100mhz_i) begin
		if (take_op) begin
			data_r <= {{(ARCHBITSZ-GPIOCOUNT){1'b0}}, addr_i ? gpo_r : gp_sync};
		end
	end

	// after each pulse the counter forces a dark cycle
	always_ff @(posedge clk100mhz_i) begin
		if (sys_rst_i) begin
			activity      <= 1'b0;
			activity_cntr <= '0;
		end else if (activity_cntr != '0) begin
			activity      <= 1'b0;
			activity_cntr <= activity_cntr - 1'b1;
		end else if (!(sd_di_i && sd_do_i) || dram_init_error_i) begin
			activity      <= 1'b1;
			activity_cntr <= '1;
		end
	end

	assign data_o = data_r;
	assign rdy_o  = (op_i == PI1_NOOP) || ack_r;
	assign gp_o   = {gpo_r[GPIOCOUNT-1:1], gpo_r[0] | activity};

endmodule

//--- devtbl/reset_seq.sv
// power-on reset hold counter with warm restart and power-off latch
`timescale 1ns/1ns

module reset_seq
	import soc_pkg::*;
(
	input  logic clk100mhz_i,
	input  logic rst_p,
	input  logic pll_locked_i,
	input  logic pu_rst_req_i,
	input  logic soft_warm_i,
	input  logic soft_off_i,
	output logic sys_rst_o
);

	logic [RST_CNTR_BITSZ-1:0] rst_cntr;
	logic                      off_r;
	logic                      hold;

	// any of these restarts the full hold time
	assign hold = !pll_locked_i || pu_rst_req_i || soft_warm_i;

	always_ff @(posedge clk100mhz_i) begin
		if (rst_p || hold) begin
			rst_cntr <= RST_HOLD_CYCLES;
		end else if (rst_cntr != '0) begin
			rst_cntr <= rst_cntr - 1'b1;
		end
	end

	// powered off until the external reset
	always_ff @(posedge clk100mhz_i) begin
		if (rst_p) begin
			off_r <= 1'b0;
		end else if (soft_off_i) begin
			off_r <= 1'b1;
		end
	end

	assign sys_rst_o = (rst_cntr != '0) || off_r || !pll_locked_i;

	// the latch holds the system in reset until rst_p
	a_off_sticky: assert property (@(posedge clk100mhz_i) disable iff (rst_p)
		$past(off_r) |-> (off_r && sys_rst_o));

endmodule

//--- devtbl/dev_table.sv
// device table read registers and software reset control word
`timescale 1ns/1ns

module dev_table
	import soc_pkg::*;
	import devmap_pkg::*;
(
	input  logic                 clk100mhz_i,
	input  logic                 sys_rst_i,
	input  pi1_op_t              op_i,
	input  logic [3:0]           addr_i,
	input  logic [ARCHBITSZ-1:0] data_i,
	input  logic [SELBITSZ-1:0]  sel_i,
	output logic [ARCHBITSZ-1:0] data_o,
	output logic                 rdy_o,
	output logic                 soft_warm_o,
	output logic                 soft_off_o
);

	logic                 ack_r;
	logic [ARCHBITSZ-1:0] data_r;
	logic [ARCHBITSZ-1:0] rd_word;
	logic                 take_op;
	logic                 ctrl_wr;

	// first cycle of an access before the ack
	assign take_op = (op_i != PI1_NOOP) && !ack_r;
	assign ctrl_wr = take_op && ((op_i == PI1_WRITE) || (op_i == PI1_RDWR)) &&
		(addr_i == DEVTBL_CTRL_WORD) && sel_i[0];

	// even words hold ids, odd words hold map sizes in bytes
	always_comb begin
		rd_word = '0;
		for (int k = 0; k < SLAVECOUNT; k++) begin
			if (addr_i[3:1] == 3'(k)) begin
				rd_word = addr_i[0] ? {DEV_MAPSZ[k], 2'b00} : DEV_ID[k];
			end
		end
	end

	always_ff @(posedge clk100mhz_i) begin
		if (sys_rst_i) begin
			ack_r <= 1'b0;
		end else begin
			ack_r <= take_op;
		end
	end

	always_ff @(posedge clk100mhz_i) begin
		if (take_op) begin
			data_r <= rd_word;
		end
	end

	// bit 1 restarts the system, bit 0 alone powers it off
	always_ff @(posedge clk100mhz_i) begin
		if (sys_rst_i) begin
			soft_warm_o <= 1'b0;
			soft_off_o  <= 1'b0;
		end else begin
			soft_warm_o <= ctrl_wr && data_i[1];
			soft_off_o  <= ctrl_wr && (data_i[1:0] == 2'b01);
		end
	end

	assign data_o = data_r;
	assign rdy_o  = (op_i == PI1_NOOP) || ack_r;

	// ready rises only to answer an access that is still held
	a_rdy_after_op: assert property (@(posedge clk100mhz_i) disable iff (sys_rst_i)
		(!rdy_o ##1 rdy_o) |-> (op_i != PI1_NOOP));

endmodule

//--- src/pi1_decoder.sv
// bus address decoder with default slave and read data return mux
`timescale 1ns/1ns

module pi1_decoder
	import soc_pkg::*;
	import devmap_pkg::*;
(
	input  logic                 clk100mhz_i,
	input  pi1_op_t              pi1_op_i,
	input  logic [ADDRBITSZ-1:0] pi1_addr_i,
	input  logic [ARCHBITSZ-1:0] devtbl_data_i,
	input  logic                 devtbl_rdy_i,
	input  logic [ARCHBITSZ-1:0] gpio_data_i,
	input  logic                 gpio_rdy_i,
	output pi1_op_t              devtbl_op_o,
	output pi1_op_t              gpio_op_o,
	output logic [ARCHBITSZ-1:0] pi1_data_o,
	output logic                 pi1_rdy_o
);

	slave_idx_t slave_sel;

	function automatic logic in_map(logic [ADDRBITSZ-1:0] addr, slave_idx_t idx);
		return (addr >= DEV_BASE[idx]) && (addr < (DEV_BASE[idx] + DEV_MAPSZ[idx]));
	endfunction

	// anything outside the real slaves lands on the default slave
	always_comb begin
		slave_sel = S_INVALIDDEV;
		if (in_map(pi1_addr_i, S_DEVTBL)) begin
			slave_sel = S_DEVTBL;
		end else if (in_map(pi1_addr_i, S_GPIO)) begin
			slave_sel = S_GPIO;
		end
	end

	assign devtbl_op_o = (slave_sel == S_DEVTBL) ? pi1_op_i : PI1_NOOP;
	assign gpio_op_o   = (slave_sel == S_GPIO) ? pi1_op_i : PI1_NOOP;

	// default slave answers at once with zero
	always_comb begin
		case (slave_sel)
			S_DEVTBL: begin
				pi1_data_o = devtbl_data_i;
				pi1_rdy_o  = devtbl_rdy_i;
			end
			S_GPIO: begin
				pi1_data_o = gpio_data_i;
				pi1_rdy_o  = gpio_rdy_i;
			end
			default: begin
				pi1_data_o = '0;
				pi1_rdy_o  = 1'b1;
			end
		endcase
	end

	// an access stays with one slave until it is answered
	a_one_slave: assert property (@(posedge clk100mhz_i)
		((pi1_op_i != PI1_NOOP) && !pi1_rdy_o) |=> ($stable(slave_sel) && $stable(pi1_op_i)));

endmodule

//--- common/devmap_pkg.sv
// slave indices, device ids, map sizes and base addresses of the bus map
package devmap_pkg;

	import soc_pkg::*;

	// order here is the order of the address map
	typedef enum logic [1:0] {
		S_DEVTBL     = 2'd0,
		S_GPIO       = 2'd1,
		S_INVALIDDEV = 2'd2
	} slave_idx_t;

	localparam int SLAVECOUNT = 3;

	// id reported by the device table, 0 for the catch-all slave
	localparam logic [ARCHBITSZ-1:0] DEV_ID [SLAVECOUNT] = '{32'd7, 32'd6, 32'd0};

	// map sizes in words
	localparam logic [ADDRBITSZ-1:0] DEV_MAPSZ [SLAVECOUNT] = '{30'd16, 30'd4, 30'd1024};

	// slaves sit back to back from word zero
	localparam logic [ADDRBITSZ-1:0] DEV_BASE [SLAVECOUNT] = '{
		30'd0,
		DEV_MAPSZ[0],
		DEV_MAPSZ[0] + DEV_MAPSZ[1]
	};

	// software reset control word inside the device table
	localparam logic [3:0] DEVTBL_CTRL_WORD = 4'd15;

endpackage

//--- common/soc_pkg.sv
// bus widths, bus op encoding, reset hold and activity stretcher constants
package soc_pkg;

	// one bus word and its word address
	localparam int ARCHBITSZ = 32;
	localparam int ADDRBITSZ = 30;
	localparam int SELBITSZ  = 4;

	// peripheral bus op, held by the master until rdy
	typedef enum logic [1:0] {
		PI1_NOOP  = 2'b00,
		PI1_WRITE = 2'b01,
		PI1_READ  = 2'b10,
		PI1_RDWR  = 2'b11
	} pi1_op_t;

	// reset hold after the clock generator locks
	localparam int RST_CNTR_BITSZ = 8;
	localparam logic [RST_CNTR_BITSZ-1:0] RST_HOLD_CYCLES = 8'd255;

	// activity led dimming, one cycle on then one off
	localparam int ACTIVITY_CNTR_BITSZ = 1;

	localparam int GPIOCOUNT = 8;

endpackage
